// File: test/bc_msg_patterns.txt
# phase core addr(hex) mask(hex) data(hex) gap repeat
# repeat copies step addr and data by one; phase 1 single, 2 saturation, 3 random gaps
1 5 07a f deadbeef 0 1
2 0 100 f a5000000 0 8
2 1 110 3 a5010000 0 8
2 2 120 c a5020000 0 8
2 3 130 f a5030000 0 8
2 4 140 1 a5040000 0 8
2 5 150 2 a5050000 0 8
2 6 160 4 a5060000 0 8
2 7 170 8 a5070000 0 8
2 8 180 f a5080000 0 8
2 9 190 6 a5090000 0 8
2 10 1a0 9 a50a0000 0 8
2 11 1b0 f a50b0000 0 8
2 12 1c0 e a50c0000 0 8
2 13 1d0 7 a50d0000 0 8
2 14 1e0 b a50e0000 0 8
2 15 1f0 f a50f0000 0 8
3 3 200 f 12345678 0 2
3 7 204 1 0badf00d 2 1
3 12 208 3 cafe0001 1 3
3 0 20c f 00000000 0 1
3 15 210 8 ffffffff 3 2
3 9 214 c 13579bdf 0 2
3 4 218 f 2468ace0 1 1
3 10 21c 5 5a5a5a5a 0 3
3 1 220 f a5a5a5a5 2 2
3 14 224 2 76543210 0 1
3 6 228 f 89abcdef 1 2
3 11 22c a 11111111 0 1
3 2 230 f 22222222 4 2
3 13 234 4 33333333 0 3
3 8 238 f 44444444 1 1
3 5 23c 6 55555555 0 2
3 3 240 f 66666666 2 1
3 12 244 9 77777777 0 2
3 0 248 f 88888888 1 3
3 15 24c 1 99999999 0 1
3 7 250 f aaaaaaaa 0 2
3 9 254 3 bbbbbbbb 5 1
3 4 258 f cccccccc 0 2
3 10 25c c dddddddd 1 1
3 1 260 f eeeeeeee 0 3
3 14 264 7 01020304 2 2
3 6 268 f 05060708 0 1
3 11 26c e 090a0b0c 1 2
3 2 270 f 0d0e0f10 0 1
3 13 274 b 11121314 3 2
3 8 278 f 15161718 0 3
3 5 27c d 191a1b1c 1 1
3 3 280 f 1d1e1f20 0 2
3 12 284 2 21222324 2 1
3 0 288 f 25262728 0 2
3 15 28c 8 292a2b2c 1 3
3 7 290 f 2d2e2f30 0 1
3 9 294 4 31323334 2 2
3 4 298 f 35363738 0 1
3 10 29c 1 393a3b3c 1 2
3 1 2a0 f 3d3e3f40 0 1
3 14 2a4 6 41424344 3 2
3 6 2a8 f 45464748 0 3
3 11 2ac 3 494a4b4c 0 1
3 2 2b0 f 4d4e4f50 1 2
3 13 2b4 c 51525354 0 1
3 8 2b8 f 55565758 2 2
3 5 2bc 9 595a5b5c 0 3
3 0 7fc f 5d5e5f60 0 4

// File: files.f
+incdir+include
+incdir+test
rtl/bc_msg_pkg.sv
rtl/bc_msg_ingress.sv
rtl/bc_rr_arb.sv
rtl/bc_msg_fanout.sv
rtl/bc_msg_merger.sv
test/tb_bc_msg_merger.sv

// File: Makefile
TOP = tb_bc_msg_merger
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

lint:
	verilator --lint-only -Wall \
		rtl/bc_msg_pkg.sv \
		rtl/bc_msg_ingress.sv \
		rtl/bc_rr_arb.sv \
		rtl/bc_msg_fanout.sv \
		rtl/bc_msg_merger.sv \
		--top-module bc_msg_merger

clean:
	rm -rf obj_dir $(LOG)

// File: include/bc_msg_defs.svh
`ifndef BC_MSG_DEFS_SVH
`define BC_MSG_DEFS_SVH

// Shared types for the testbench side of the broadcast merger
//
// Widths as seen on the wire
//   bc_msg_t  : data 32 + mask 4 + addr 11 = 47 bits
//   bc_flit_t : bc_msg_t + src 4           = 51 bits
// Address is a word index into the 8 KB broadcast region

// Per-source queue of expected flits
typedef bc_msg_pkg::bc_flit_t bc_flit_q_t [$];

// One bit per core, same layout as in_valid, in_ready and out_valid
typedef logic [bc_msg_pkg::CORE_COUNT-1:0] bc_core_vec_t;

// Core number, as carried in the src field
typedef logic [bc_msg_pkg::CORE_W-1:0] bc_core_id_t;

`endif

// File: test/tb_bc_msg_checks.svh
`ifndef TB_BC_MSG_CHECKS_SVH
`define TB_BC_MSG_CHECKS_SVH

// Expected flits and their accept cycles, one queue per source core
bc_flit_q_t exp_q [bc_msg_pkg::CORE_COUNT];
int         acc_q [bc_msg_pkg::CORE_COUNT][$];

// Output index of the last flit seen from each core, -1 if none yet
int last_out [bc_msg_pkg::CORE_COUNT];
int total_out = 0;

task automatic abort_run();
  $display("FAIL: see errors above");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_flit(input bc_flit_t exp, input bc_flit_t act, input string name);
  if (act !== exp) begin
    $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_valid(input bc_core_vec_t exp, input bc_core_vec_t act, input string name);
  if (act !== exp) begin
    $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_latency(input int exp, input int act);
  if (act != exp) begin
    $display("Error at %0t: out_valid latency expected %0d, got %0d", $time, exp, act);
    abort_run();
  end
endtask

// At most 30 other flits between two from the same core while all cores wait
task automatic check_fairness(input bc_core_id_t s);
  bit all_pending;
  all_pending = 1'b1;
  for (int i = 0; i < CORE_COUNT; i++) begin
    if (exp_q[i].size() == 0 && stim_q[i].size() == 0) begin
      all_pending = 1'b0;
    end
  end
  if (all_pending && last_out[s] >= 0 && total_out - last_out[s] - 1 > 30) begin
    $display("Core %0d waited for %0d other messages at %0t, more than 30 is unfair",
             s, total_out - last_out[s] - 1, $time);
    abort_run();
  end
  last_out[s] = total_out;
endtask

// Match one broadcast cycle against the head of its source queue
task automatic score_output();
  bc_core_id_t s;
  bc_flit_t    exp_flit;
  int          acc;
  s = out_flit[0].src;
  if (exp_q[s].size() == 0) begin
    $display("A flit from core %0d came out at %0t, but no message from it was pending",
             s, $time);
    abort_run();
  end else begin
    check_fairness(s);
    exp_flit = exp_q[s].pop_front();
    acc      = acc_q[s].pop_front();
    for (int j = 0; j < CORE_COUNT; j++) begin
      check_flit(exp_flit, out_flit[j], $sformatf("out_flit[%0d]", j));
    end
    // No contention in the single-message phase
    // Cores sample out_valid on the next rising edge
    if (phase == 1) begin
      check_latency(5, cyc + 1 - acc);
    end
    total_out++;
  end
endtask

`endif

// File: test/tb_bc_msg_merger.sv
`timescale 1ns/1ps

module tb_bc_msg_merger;

  import bc_msg_pkg::*;

  `include "bc_msg_defs.svh"

  logic         clk;
  logic         rst = 1'b1;
  bc_core_vec_t in_valid = '0;
  bc_core_vec_t in_ready;
  bc_msg_t      in_msg [CORE_COUNT] = '{default: '0};
  bc_core_vec_t out_valid;
  bc_flit_t     out_flit [CORE_COUNT];

  // Messages still to be offered by each core, with the idle gap after each
  bc_msg_t stim_q   [CORE_COUNT][$];
  int      gap_q    [CORE_COUNT][$];
  int      wait_cnt [CORE_COUNT];

  // Records from the pattern file
  int      rec_phase [$];
  int      rec_src   [$];
  bc_msg_t rec_msg   [$];
  int      rec_gap   [$];
  int      rec_rep   [$];

  int          cyc = 0;
  int          phase = 0;
  bit          reset_seen = 1'b0;
  bit          saw_backpressure = 1'b0;
  logic [31:0] rnd = 32'h44d1;

  `include "tb_bc_msg_checks.svh"

  bc_msg_merger dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_msg    (in_msg),
    .out_valid (out_valid),
    .out_flit  (out_flit)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit all_drained();
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (stim_q[i].size() != 0 || exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    int          ph;
    int          sc;
    int          gp;
    int          rp;
    logic [31:0] ad;
    logic [31:0] mk;
    logic [31:0] dt;
    fd = $fopen("test/bc_msg_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/bc_msg_patterns.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line[0] != "#") begin
        cnt = $sscanf(line, "%d %d %h %h %h %d %d", ph, sc, ad, mk, dt, gp, rp);
        if (cnt == 7) begin
          rec_phase.push_back(ph);
          rec_src.push_back(sc);
          rec_msg.push_back(bc_msg_t'{data: dt, mask: mk[MASK_W-1:0], addr: ad[ADDR_W-1:0]});
          rec_gap.push_back(gp);
          rec_rep.push_back(rp);
        end else if (cnt > 0) begin
          $display("Malformed line in the pattern file: %s", line);
          abort_run();
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_drained(input int p, input int limit);
    int n;
    n = 0;
    while (!all_drained() && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!all_drained()) begin
      $display("Timeout: phase %0d still had messages in flight after %0d cycles", p, limit);
      abort_run();
    end
  endtask

  // Queue every message of one phase, then wait for all of them to come out
  task automatic run_phase(input int p);
    bc_msg_t m;
    int      g;
    @(negedge clk);
    phase = p;
    for (int i = 0; i < CORE_COUNT; i++) begin
      last_out[i] = -1;
    end
    for (int r = 0; r < rec_src.size(); r++) begin
      if (rec_phase[r] == p) begin
        for (int k = 0; k < rec_rep[r]; k++) begin
          m      = rec_msg[r];
          m.addr = m.addr + ADDR_W'(k);
          m.data = m.data + DATA_W'(k);
          g      = rec_gap[r];
          // Phase 3 mixes in random idle cycles
          if (p == 3) begin
            rnd = xorshift32(rnd);
            g   = g + int'(rnd % 4);
          end
          stim_q[rec_src[r]].push_back(m);
          gap_q[rec_src[r]].push_back(g);
        end
      end
    end
    wait_drained(p, 3000);
  endtask

  // Core side: offer the head message, hold it until accepted, then idle
  always @(posedge clk) begin
    bc_flit_t f;
    bit       held;
    if (rst) begin
      cyc        = 0;
      reset_seen = 1'b1;
    end else begin
      cyc = cyc + 1;
      for (int i = 0; i < CORE_COUNT; i++) begin
        held = in_valid[i] & ~in_ready[i];
        if (in_valid[i] && in_ready[i]) begin
          f.msg = stim_q[i][0];
          f.src = bc_core_id_t'(i);
          exp_q[i].push_back(f);
          acc_q[i].push_back(cyc);
          wait_cnt[i] = gap_q[i].pop_front();
          void'(stim_q[i].pop_front());
        end
        if (!held) begin
          if (wait_cnt[i] > 0) begin
            wait_cnt[i]--;
            in_valid[i] <= 1'b0;
          end else if (stim_q[i].size() > 0) begin
            in_valid[i] <= 1'b1;
            in_msg[i]   <= stim_q[i][0];
          end else begin
            in_valid[i] <= 1'b0;
          end
        end
      end
    end
  end

  // Output monitor, sampled away from the active edge
  always @(negedge clk) begin
    if (reset_seen) begin
      if (rst || cyc == 0) begin
        check_valid('1, in_ready, "in_ready");
        check_valid('0, out_valid, "out_valid");
      end else begin
        check_valid({CORE_COUNT{out_valid[0]}}, out_valid, "out_valid");
        if (out_valid[0]) begin
          score_output();
        end
        if (phase == 2 && in_ready != '1) begin
          saw_backpressure = 1'b1;
        end
      end
    end
  end

  initial begin
    for (int i = 0; i < CORE_COUNT; i++) begin
      wait_cnt[i] = 0;
      last_out[i] = -1;
    end
    load_patterns();
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Single message, then saturation, then random gaps
    run_phase(1);
    run_phase(2);
    run_phase(3);

    // Path is five stages deep, so a duplicate flit would surface within this window
    repeat (8) @(negedge clk);

    if (saw_backpressure) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("in_ready never dropped while all cores were saturating the merger");
      abort_run();
    end
  end

endmodule

// File: rtl/bc_msg_merger.sv
`timescale 1ns/1ps

module bc_msg_merger (
  input  logic                              clk,
  input  logic                              rst,

  // Messages from every core
  input  logic [bc_msg_pkg::CORE_COUNT-1:0] in_valid,
  output logic [bc_msg_pkg::CORE_COUNT-1:0] in_ready,
  input  bc_msg_pkg::bc_msg_t               in_msg [bc_msg_pkg::CORE_COUNT],

  // Merged broadcast to every core, cores always accept
  output logic [bc_msg_pkg::CORE_COUNT-1:0] out_valid,
  output bc_msg_pkg::bc_flit_t              out_flit [bc_msg_pkg::CORE_COUNT]
);

  import bc_msg_pkg::*;

  // Ingress outputs grouped by cluster
  logic [CORES_PER_CLUSTER-1:0] ing_valid [CLUSTER_COUNT];
  logic [CORES_PER_CLUSTER-1:0] ing_ready [CLUSTER_COUNT];
  bc_flit_t                     ing_flit  [CLUSTER_COUNT][CORES_PER_CLUSTER];

  // Cluster arbiter outputs
  logic [CLUSTER_COUNT-1:0] cl_valid;
  logic [CLUSTER_COUNT-1:0] cl_ready;
  bc_flit_t                 cl_flit [CLUSTER_COUNT];

  // Single merged stream
  logic     mrg_valid;
  bc_flit_t mrg_flit;

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_ingress
    bc_msg_ingress u_ingress (
      .clk       (clk),
      .rst       (rst),
      .src       (CORE_W'(i)),
      .in_valid  (in_valid[i]),
      .in_ready  (in_ready[i]),
      .in_msg    (in_msg[i]),
      .out_valid (ing_valid[i / CORES_PER_CLUSTER][i % CORES_PER_CLUSTER]),
      .out_ready (ing_ready[i / CORES_PER_CLUSTER][i % CORES_PER_CLUSTER]),
      .out_flit  (ing_flit[i / CORES_PER_CLUSTER][i % CORES_PER_CLUSTER])
    );
  end

  // First level, one arbiter per cluster
  for (genvar c = 0; c < CLUSTER_COUNT; c++) begin : g_cluster
    bc_rr_arb #(
      .n_req (CORES_PER_CLUSTER)
    ) u_cluster_arb (
      .clk       (clk),
      .rst       (rst),
      .req_valid (ing_valid[c]),
      .req_ready (ing_ready[c]),
      .req_flit  (ing_flit[c]),
      .out_valid (cl_valid[c]),
      .out_ready (cl_ready[c]),
      .out_flit  (cl_flit[c])
    );
  end

  // Second level merges the clusters; the fan-out never stalls
  bc_rr_arb #(
    .n_req (CLUSTER_COUNT)
  ) u_merge_arb (
    .clk       (clk),
    .rst       (rst),
    .req_valid (cl_valid),
    .req_ready (cl_ready),
    .req_flit  (cl_flit),
    .out_valid (mrg_valid),
    .out_ready (1'b1),
    .out_flit  (mrg_flit)
  );

  bc_msg_fanout u_fanout (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (mrg_valid),
    .in_flit   (mrg_flit),
    .out_valid (out_valid),
    .out_flit  (out_flit)
  );

endmodule

// File: rtl/bc_msg_fanout.sv
`timescale 1ns/1ps

module bc_msg_fanout (
  input  logic                                 clk,
  input  logic                                 rst,

  // Merged stream, always accepted
  input  logic                                 in_valid,
  input  bc_msg_pkg::bc_flit_t                 in_flit,

  // One copy per core
  output logic [bc_msg_pkg::CORE_COUNT-1:0]    out_valid,
  output bc_msg_pkg::bc_flit_t                 out_flit [bc_msg_pkg::CORE_COUNT]
);

  import bc_msg_pkg::*;

  // Stage 1 holds one copy per cluster
  logic [CLUSTER_COUNT-1:0] s1_valid;
  bc_flit_t                 s1_flit [CLUSTER_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= '0;
      out_valid <= '0;
    end else begin
      s1_valid <= {CLUSTER_COUNT{in_valid}};
      for (int j = 0; j < CORE_COUNT; j++) begin
        out_valid[j] <= s1_valid[j / CORES_PER_CLUSTER];
      end
    end
  end

  // Stage 2 feeds each core from its own cluster's copy
  always_ff @(posedge clk) begin
    for (int c = 0; c < CLUSTER_COUNT; c++) begin
      s1_flit[c] <= in_flit;
    end
    for (int j = 0; j < CORE_COUNT; j++) begin
      out_flit[j] <= s1_flit[j / CORES_PER_CLUSTER];
    end
  end

endmodule

// File: rtl/bc_rr_arb.sv
`timescale 1ns/1ps

module bc_rr_arb #(
  parameter int n_req = 4
) (
  input  logic                 clk,
  input  logic                 rst,

  // Request side, one valid/ready pair per requester
  input  logic [n_req-1:0]     req_valid,
  output logic [n_req-1:0]     req_ready,
  input  bc_msg_pkg::bc_flit_t req_flit [n_req],

  // Registered output
  output logic                 out_valid,
  input  logic                 out_ready,
  output bc_msg_pkg::bc_flit_t out_flit
);

  // At least one bit, so a single requester still builds
  localparam int IDX_W = (n_req > 1) ? $clog2(n_req) : 1;

  // Next request to get first chance
  logic [IDX_W-1:0] ptr;

  logic             grant_found;
  logic [IDX_W-1:0] grant_idx;
  logic             load_ok;
  logic             take;

  // Output register is free if empty or draining this cycle
  assign load_ok = ~out_valid | out_ready;
  assign take    = load_ok & grant_found;

  // First valid request at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = 0; i < n_req; i++) begin
      idx = (int'(ptr) + i) % n_req;
      if (!grant_found && req_valid[idx]) begin
        grant_found = 1'b1;
        grant_idx   = idx[IDX_W-1:0];
      end
    end
  end

  // Only the granted requester sees ready
  always_comb begin
    req_ready = '0;
    if (take) begin
      req_ready[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ptr       <= '0;
    end else begin
      if (take) begin
        out_valid <= 1'b1;
        // Pointer moves one past the winner
        if (grant_idx == IDX_W'(n_req - 1)) begin
          ptr <= '0;
        end else begin
          ptr <= grant_idx + 1'b1;
        end
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // Reload on the same edge the held flit leaves
  always_ff @(posedge clk) begin
    if (take) begin
      out_flit <= req_flit[grant_idx];
    end
  end

endmodule

// File: rtl/bc_msg_ingress.sv
`timescale 1ns/1ps

module bc_msg_ingress (
  input  logic                          clk,
  input  logic                          rst,

  // Core number this register belongs to
  input  logic [bc_msg_pkg::CORE_W-1:0] src,

  // From the core
  input  logic                          in_valid,
  output logic                          in_ready,
  input  bc_msg_pkg::bc_msg_t           in_msg,

  // Toward the cluster arbiter
  output logic                          out_valid,
  input  logic                          out_ready,
  output bc_msg_pkg::bc_flit_t          out_flit
);

  import bc_msg_pkg::*;

  // Main entry is what is offered downstream
  logic     main_valid;
  bc_flit_t main_flit;
  // Skid entry catches a message while main is stalled
  logic     skid_valid;
  bc_flit_t skid_flit;

  bc_flit_t in_flit;
  logic     in_fire;
  logic     main_free;

  assign in_flit = '{msg: in_msg, src: src};

  // Ready is just the inverted skid flag, so it comes straight from a flop
  assign in_ready  = ~skid_valid;
  assign in_fire   = in_valid & in_ready;
  assign main_free = ~main_valid | out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // Main leaves or is empty, refill from skid first to keep order
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_fire;
      end
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      main_flit <= skid_valid ? skid_flit : in_flit;
    end
    if (!main_free && in_fire) begin
      skid_flit <= in_flit;
    end
  end

  assign out_valid = main_valid;
  assign out_flit  = main_flit;

endmodule

// File: rtl/bc_msg_pkg.sv
package bc_msg_pkg;

  // Core and cluster organisation
  localparam int CORE_COUNT        = 16;
  localparam int CLUSTER_COUNT     = 4;
  localparam int CORES_PER_CLUSTER = CORE_COUNT / CLUSTER_COUNT;
  localparam int CORE_W            = 4;

  // Message fields
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;
  // Word address within the 8 KB region
  localparam int ADDR_W = 11;

  // What a core sends: one word write into the broadcast region
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
    logic [ADDR_W-1:0] addr;
  } bc_msg_t;

  // Message tagged with its sender
  // Travels through both arbitration levels and out to every core
  typedef struct packed {
    bc_msg_t           msg;
    logic [CORE_W-1:0] src;
  } bc_flit_t;

endpackage
